// File: hello_consts.svh
// Register map and sizing constants for the hello-world register block
// Shared by the RTL and the testbench

`ifndef HELLO_CONSTS_SVH
`define HELLO_CONSTS_SVH

// Bus and field widths
`define HELLO_ADDR_W 32
`define HELLO_DATA_W 32
`define HELLO_VLED_W 16
`define HELLO_TICK_W 8
`define HELLO_CNT_W  16

// ----------------------------
// Register addresses
// ----------------------------
`define HELLO_WORLD_ADDR    32'h0000_0500
`define HELLO_VLED_ADDR     32'h0000_0504
`define HELLO_CNT_CTRL_ADDR 32'h0000_0510
`define HELLO_TICK_VAL_ADDR 32'h0000_0514
`define HELLO_LOAD_VAL_ADDR 32'h0000_0518
`define HELLO_WMARK_ADDR    32'h0000_051C
`define HELLO_CNT_STAT_ADDR 32'h0000_0520

// Returned for any address outside the map
`define HELLO_UNIMPL_VALUE  32'hDEAD_DEAD

`endif

// File: hello_pkg.sv
// Shared types for the hello-world register block
// AXI-Lite request and response bundles, counter control and status

`default_nettype none

`include "hello_consts.svh"

package hello_pkg;

  // Host driven side of the OCL port
  typedef struct packed {
    logic                       awvalid;
    logic [`HELLO_ADDR_W-1:0]   awaddr;
    logic                       wvalid;
    logic [`HELLO_DATA_W-1:0]   wdata;
    logic [`HELLO_DATA_W/8-1:0] wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [`HELLO_ADDR_W-1:0]   araddr;
    logic                       rready;
  } axil_req_t;

  // Slave driven side
  typedef struct packed {
    logic                     awready;
    logic                     wready;
    logic                     bvalid;
    logic [1:0]               bresp;
    logic                     arready;
    logic                     rvalid;
    logic [`HELLO_DATA_W-1:0] rdata;
    logic [1:0]               rresp;
  } axil_rsp_t;

  // load and clear are single-cycle pulses
  typedef struct packed {
    logic                     enable;
    logic                     oneshot;
    logic                     load;
    logic                     clear;
    logic [`HELLO_TICK_W-1:0] tick_value;
    logic [`HELLO_CNT_W-1:0]  load_value;
    logic [`HELLO_CNT_W-1:0]  watermark;
  } cnt_ctrl_t;

  typedef struct packed {
    logic [`HELLO_CNT_W-1:0]  count;
    logic [`HELLO_TICK_W-1:0] tick_cnt;
    logic                     ge_watermark;
  } cnt_stat_t;

endpackage

`default_nettype wire

// File: ocl_slave.sv
// Single-beat AXI-Lite slave for the OCL register port
// Tracks one write and one read in flight and turns them into
// register strobes for the register block

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module ocl_slave (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  hello_pkg::axil_req_t     req,
  output hello_pkg::axil_rsp_t     rsp,
  output logic                     wr_stb,
  output logic [`HELLO_ADDR_W-1:0] wr_addr,
  output logic [`HELLO_DATA_W-1:0] wr_data,
  output logic                     rd_stb,
  output logic [`HELLO_ADDR_W-1:0] rd_addr,
  input  logic [`HELLO_DATA_W-1:0] rd_data
);

  logic                     out_of_rst;
  logic                     wr_active;
  logic                     bvalid_q;
  logic                     rd_pend;
  logic                     rvalid_q;
  logic [`HELLO_DATA_W-1:0] rdata_q;
  logic                     awready;
  logic                     wready;
  logic                     arready;

  // ----------------------------
  // Write channel
  // ----------------------------
  // Address is taken only after the first cycle out of reset
  assign awready = out_of_rst & ~wr_active;
  assign wready  = wr_active & req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      out_of_rst <= 1'b0;
      wr_active  <= 1'b0;
      bvalid_q   <= 1'b0;
    end else begin
      out_of_rst <= 1'b1;
      if (req.awvalid && awready) begin
        wr_active <= 1'b1;
      end else if (bvalid_q && req.bready) begin
        wr_active <= 1'b0;
      end
      if (bvalid_q && req.bready) begin
        bvalid_q <= 1'b0;
      end else if (wready) begin
        bvalid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (req.awvalid && awready) begin
      wr_addr <= req.awaddr;
    end
  end

  assign wr_stb  = wready;
  assign wr_data = req.wdata;

  // ----------------------------
  // Read channel
  // ----------------------------
  assign arready = ~rd_pend & ~rvalid_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rd_pend <= req.arvalid & arready;
      if (rd_pend) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Address held until the next accepted read, data captured on issue
  always_ff @(posedge clk_main_a0) begin
    if (req.arvalid && arready) begin
      rd_addr <= req.araddr;
    end
    if (rd_pend) begin
      rdata_q <= rd_data;
    end
  end

  assign rd_stb = rd_pend;

  assign rsp = '{awready: awready, wready: wready, bvalid: bvalid_q, bresp: 2'b00,
                 arready: arready, rvalid: rvalid_q, rdata: rdata_q, rresp: 2'b00};

  // Response stays up until the host takes it
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid_q && !req.bready) |=> bvalid_q);

  // Accepted read returns data two cycles later with arready held off
  a_read_seq: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (req.arvalid && arready) |=> !arready ##1 (rvalid_q && !arready));

  // Every write strobe belongs to an active write and is answered next cycle
  a_write_seq: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |-> wr_active ##1 bvalid_q);

endmodule

`default_nettype wire

// File: hello_regs.sv
// Register block behind the OCL slave
// Holds the hello-world word and the counter controls, makes the
// load and clear pulses and selects read data by address

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module hello_regs (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  logic                     wr_stb,
  input  logic [`HELLO_ADDR_W-1:0] wr_addr,
  input  logic [`HELLO_DATA_W-1:0] wr_data,
  input  logic                     rd_stb,
  input  logic [`HELLO_ADDR_W-1:0] rd_addr,
  output logic [`HELLO_DATA_W-1:0] rd_data,
  input  logic [`HELLO_VLED_W-1:0] vled_shadow,
  output logic [`HELLO_VLED_W-1:0] hello_low,
  output hello_pkg::cnt_ctrl_t     cnt_ctrl,
  input  hello_pkg::cnt_stat_t     cnt_stat
);

  logic [`HELLO_DATA_W-1:0] hello_q;
  logic [`HELLO_DATA_W-1:0] hello_swapped;
  logic [`HELLO_DATA_W-1:0] rd_mux;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q  <= '0;
      cnt_ctrl <= '0;
    end else begin
      // Pulses drop again unless this cycle writes them
      cnt_ctrl.load  <= 1'b0;
      cnt_ctrl.clear <= 1'b0;
      if (wr_stb) begin
        case (wr_addr)
          `HELLO_WORLD_ADDR: hello_q <= wr_data;
          `HELLO_CNT_CTRL_ADDR: begin
            cnt_ctrl.enable  <= wr_data[0];
            cnt_ctrl.oneshot <= wr_data[1];
            cnt_ctrl.load    <= wr_data[2];
            cnt_ctrl.clear   <= wr_data[3];
          end
          `HELLO_TICK_VAL_ADDR: cnt_ctrl.tick_value <= wr_data[`HELLO_TICK_W-1:0];
          `HELLO_LOAD_VAL_ADDR: cnt_ctrl.load_value <= wr_data[`HELLO_CNT_W-1:0];
          `HELLO_WMARK_ADDR:    cnt_ctrl.watermark  <= wr_data[`HELLO_CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign hello_low     = hello_q[`HELLO_VLED_W-1:0];
  // Byte order reversed on read back
  assign hello_swapped = {<<8{hello_q}};

  // ----------------------------
  // Read data select
  // ----------------------------
  always_comb begin
    case (rd_addr)
      `HELLO_WORLD_ADDR:    rd_mux = hello_swapped;
      `HELLO_VLED_ADDR:     rd_mux = {{(`HELLO_DATA_W-`HELLO_VLED_W){1'b0}}, vled_shadow};
      `HELLO_CNT_CTRL_ADDR: rd_mux = {{(`HELLO_DATA_W-2){1'b0}}, cnt_ctrl.oneshot,
                                      cnt_ctrl.enable};
      `HELLO_TICK_VAL_ADDR: rd_mux = {{(`HELLO_DATA_W-`HELLO_TICK_W){1'b0}},
                                      cnt_ctrl.tick_value};
      `HELLO_LOAD_VAL_ADDR: rd_mux = {{(`HELLO_DATA_W-`HELLO_CNT_W){1'b0}},
                                      cnt_ctrl.load_value};
      `HELLO_WMARK_ADDR:    rd_mux = {{(`HELLO_DATA_W-`HELLO_CNT_W){1'b0}},
                                      cnt_ctrl.watermark};
      `HELLO_CNT_STAT_ADDR: rd_mux = {{(`HELLO_DATA_W-1-`HELLO_TICK_W-`HELLO_CNT_W){1'b0}},
                                      cnt_stat.ge_watermark, cnt_stat.tick_cnt,
                                      cnt_stat.count};
      default:              rd_mux = `HELLO_UNIMPL_VALUE;
    endcase
  end

  // Bus held at zero outside the issue cycle
  assign rd_data = rd_stb ? rd_mux : '0;

  // One write per pulse, so the slave never strobes two cycles running
  a_load_pulse: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_ctrl.load |=> !cnt_ctrl.load);

  a_clear_pulse: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_ctrl.clear |=> !cnt_ctrl.clear);

endmodule

`default_nettype wire

// File: vled_ctrl.sv
// Virtual LED output
// Shadows the hello-world low half, synchronizes the DIP switches
// over two stages and drives the LEDs masked by the switches

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module vled_ctrl (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  logic [`HELLO_VLED_W-1:0] hello_low,
  input  logic [`HELLO_VLED_W-1:0] vdip,
  output logic [`HELLO_VLED_W-1:0] vled_shadow,
  output logic [`HELLO_VLED_W-1:0] vled
);

  logic [`HELLO_VLED_W-1:0] vdip_q1;
  logic [`HELLO_VLED_W-1:0] vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_shadow <= '0;
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      vled        <= '0;
    end else begin
      vled_shadow <= hello_low;
      // Switches come from another domain
      vdip_q1     <= vdip;
      vdip_q2     <= vdip_q1;
      // Only LEDs whose switch is on light up
      vled        <= vled_shadow & vdip_q2;
    end
  end

endmodule

`default_nettype wire

// File: tick_counter.sv
// Tick-divided event counter
// A prescaler divides the clock down to ticks, the main counter
// counts ticks and either wraps or saturates in one-shot mode.
// The watermark flag trails the count by one cycle.

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module tick_counter (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  input  hello_pkg::cnt_ctrl_t ctrl,
  output hello_pkg::cnt_stat_t stat
);

  localparam logic [`HELLO_CNT_W-1:0] CNT_MAX = {`HELLO_CNT_W{1'b1}};

  logic tick;
  logic at_max;

  assign tick   = ctrl.enable && (stat.tick_cnt >= ctrl.tick_value);
  assign at_max = (stat.count == CNT_MAX);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      stat <= '0;
    end else begin
      // Prescaler
      if (ctrl.clear || tick) begin
        stat.tick_cnt <= '0;
      end else if (ctrl.enable) begin
        stat.tick_cnt <= stat.tick_cnt + 1'b1;
      end

      // Clear beats load, load beats counting
      if (ctrl.clear) begin
        stat.count <= '0;
      end else if (ctrl.load) begin
        stat.count <= ctrl.load_value;
      end else if (tick && !(ctrl.oneshot && at_max)) begin
        stat.count <= stat.count + 1'b1;
      end

      stat.ge_watermark <= (stat.count >= ctrl.watermark);
    end
  end

  // Saturated count only moves through load or clear
  a_oneshot_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ctrl.oneshot && at_max && !ctrl.load && !ctrl.clear) |=> (stat.count == CNT_MAX));

endmodule

`default_nettype wire

// File: hello_top.sv
// Hello-world register block top level
// OCL slave, register file, virtual LED logic and event counter

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module hello_top (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  hello_pkg::axil_req_t     ocl_req,
  output hello_pkg::axil_rsp_t     ocl_rsp,
  input  logic [`HELLO_VLED_W-1:0] vdip,
  output logic [`HELLO_VLED_W-1:0] vled
);

  import hello_pkg::*;

  logic                     wr_stb;
  logic [`HELLO_ADDR_W-1:0] wr_addr;
  logic [`HELLO_DATA_W-1:0] wr_data;
  logic                     rd_stb;
  logic [`HELLO_ADDR_W-1:0] rd_addr;
  logic [`HELLO_DATA_W-1:0] rd_data;
  logic [`HELLO_VLED_W-1:0] hello_low;
  logic [`HELLO_VLED_W-1:0] vled_shadow;
  cnt_ctrl_t                cnt_ctrl;
  cnt_stat_t                cnt_stat;

  // Host port
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .wr_stb          (wr_stb),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_stb          (rd_stb),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_stb          (wr_stb),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_stb          (rd_stb),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vled_shadow     (vled_shadow),
    .hello_low       (hello_low),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_stat        (cnt_stat)
  );

  vled_ctrl u_vled_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .vled_shadow     (vled_shadow),
    .vled            (vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ctrl            (cnt_ctrl),
    .stat            (cnt_stat)
  );

endmodule

`default_nettype wire

// File: tb_hello.sv
// Self-checking testbench for the hello-world register block
// Replays the operations of the trace file over the OCL port,
// compares read data and the LED output with the trace values

`timescale 1ns/1ps
`default_nettype none

`include "hello_consts.svh"

module tb_hello;

  import hello_pkg::*;

  logic                     clk_main_a0 = 1'b0;
  logic                     rst_main_n_sync;
  axil_req_t                ocl_req;
  axil_rsp_t                ocl_rsp;
  logic [`HELLO_VLED_W-1:0] vdip;
  logic [`HELLO_VLED_W-1:0] vled;

  // Parsed trace
  string                    op_q[$];
  string                    name_q[$];
  logic [31:0]              addr_q[$];
  logic [31:0]              val_q[$];

  int                       cycle_cnt = 0;
  int                       cycle_limit = 0;
  int                       err_cnt = 0;
  int                       check_cnt = 0;
  int                       test_err = 0;
  int                       test_checks = 0;
  int                       tests_passed = 0;
  int                       tests_failed = 0;

  hello_top dut_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  always #5 clk_main_a0 = ~clk_main_a0;

  // Watchdog, armed once the trace length is known
  always @(posedge clk_main_a0) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the trace", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    test_checks++;
    if (expected !== actual) begin
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      err_cnt++;
      test_err++;
    end
  endtask

  // ----------------------------
  // Host side of the OCL port
  // ----------------------------
  task automatic host_write(input string name, input logic [31:0] addr,
                            input logic [31:0] data);
    int delay;
    delay = $urandom % 4;
    @(posedge clk_main_a0);
    ocl_req.awvalid <= 1'b1;
    ocl_req.awaddr  <= addr;
    ocl_req.wvalid  <= 1'b1;
    ocl_req.wdata   <= data;
    ocl_req.wstrb   <= '1;
    do @(posedge clk_main_a0); while (!ocl_rsp.awready);
    ocl_req.awvalid <= 1'b0;
    do @(posedge clk_main_a0); while (!ocl_rsp.wready);
    ocl_req.wvalid <= 1'b0;
    // Random back-pressure on the response
    repeat (delay) @(posedge clk_main_a0);
    ocl_req.bready <= 1'b1;
    do @(posedge clk_main_a0); while (!ocl_rsp.bvalid);
    // Every write answers OKAY
    check_value({name, " bresp"}, 32'h0, {30'b0, ocl_rsp.bresp});
    ocl_req.bready <= 1'b0;
  endtask

  task automatic host_read(input string name, input logic [31:0] addr,
                           output logic [31:0] data);
    int delay;
    delay = $urandom % 4;
    @(posedge clk_main_a0);
    ocl_req.arvalid <= 1'b1;
    ocl_req.araddr  <= addr;
    do @(posedge clk_main_a0); while (!ocl_rsp.arready);
    ocl_req.arvalid <= 1'b0;
    repeat (delay) @(posedge clk_main_a0);
    ocl_req.rready <= 1'b1;
    do @(posedge clk_main_a0); while (!ocl_rsp.rvalid);
    data = ocl_rsp.rdata;
    // Every read answers OKAY
    check_value({name, " rresp"}, 32'h0, {30'b0, ocl_rsp.rresp});
    ocl_req.rready <= 1'b0;
  endtask

  task automatic run_op(input int idx);
    logic [31:0] rd;
    int          gap;
    gap = $urandom % 4;
    repeat (gap) @(posedge clk_main_a0);
    if (op_q[idx] == "W") begin
      host_write(name_q[idx], addr_q[idx], val_q[idx]);
    end else if (op_q[idx] == "R") begin
      host_read(name_q[idx], addr_q[idx], rd);
      check_value(name_q[idx], val_q[idx], rd);
    end else if (op_q[idx] == "D") begin
      @(posedge clk_main_a0);
      vdip <= val_q[idx][`HELLO_VLED_W-1:0];
    end else if (op_q[idx] == "N") begin
      repeat (val_q[idx]) @(posedge clk_main_a0);
    end else if (op_q[idx] == "L") begin
      @(posedge clk_main_a0);
      check_value(name_q[idx], val_q[idx], {{(32-`HELLO_VLED_W){1'b0}}, vled});
    end else begin
      $display("Unknown operation %s in the trace for test %s", op_q[idx], name_q[idx]);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic close_test(input string name);
    if (test_err == 0) begin
      $display("test %s: ok, %0d checks", name, test_checks);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors in %0d checks", name, test_err, test_checks);
      tests_failed++;
    end
    test_err    = 0;
    test_checks = 0;
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    int          fd;
    int          n_fields;
    int          seed_ret;
    string       line;
    string       op;
    string       name;
    logic [31:0] addr;
    logic [31:0] val;

    rst_main_n_sync = 1'b0;
    ocl_req         = '0;
    vdip            = '0;
    seed_ret        = $urandom(32'h732b);

    fd = $fopen("hello_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file hello_trace.txt");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        // Skip comments and blank lines
        if (line.len() > 0 && line[0] != "#") begin
          n_fields = $sscanf(line, "%s %s %h %h", op, name, addr, val);
          if (n_fields == 4) begin
            op_q.push_back(op);
            name_q.push_back(name);
            addr_q.push_back(addr);
            val_q.push_back(val);
          end
        end
      end
      $fclose(fd);
      cycle_limit = 200 * op_q.size();

      repeat (3) @(posedge clk_main_a0);
      rst_main_n_sync <= 1'b1;

      for (int i = 0; i < op_q.size(); i++) begin
        if (i > 0 && name_q[i] != name_q[i-1]) begin
          close_test(name_q[i-1]);
        end
        run_op(i);
      end
      if (op_q.size() > 0) begin
        close_test(name_q[op_q.size()-1]);
      end

      $display("Tests run %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, check_cnt, err_cnt);
      if (check_cnt == 0) begin
        $display("No checks ran, the trace holds no read or LED operation");
      end
      if (err_cnt == 0 && check_cnt > 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
hello_pkg.sv
ocl_slave.sv
hello_regs.sv
vled_ctrl.sv
tick_counter.sv
hello_top.sv
tb_hello.sv

// File: hello_trace.txt
# op test_name addr data, addr and data in hex, unused fields are 0
# op: W write, R read and compare, D set DIP, N wait data cycles, L compare LED
W byte_swap 500 12345678
R byte_swap 500 78563412
D led_mask 0 00ff
N led_mask 0 5
L led_mask 0 0078
R led_mask 504 5678
R unimpl_addr 600 deaddead
W unimpl_addr 600 ffffffff
W unimpl_addr 508 a5a5a5a5
R unimpl_addr 500 78563412
W load_wmark 518 40
W load_wmark 51c 30
W load_wmark 510 4
R load_wmark 518 40
R load_wmark 520 01000040
W oneshot_sat 518 fffe
W oneshot_sat 514 0
W oneshot_sat 510 6
W oneshot_sat 510 3
R oneshot_sat 510 3
N oneshot_sat 0 14
R oneshot_sat 520 0100ffff
W oneshot_sat 510 8
R oneshot_sat 520 0
